// File: dino_game.f
+incdir+include
src/dino_game_pkg.sv
src/frame_timer.sv
src/game_fsm.sv
src/dino_jump.sv
src/cactus_mover.sv
src/collision_detector.sv
src/score_keeper.sv
src/dino_game.sv
verif/dino_game_tb.sv

// File: include/dino_game_params.svh
`ifndef DINO_GAME_PARAMS_SVH
`define DINO_GAME_PARAMS_SVH

// ##############################
// widths
// ##############################
`define X_W          9     // horizontal position
`define Y_W          8     // height above ground

// ##############################
// timing
// ##############################
`define FRAME_CYCLES 16    // clocks per game tick

// ##############################
// geometry, in pixels
// ##############################
`define START_X      300   // cactus spawn point
`define DINO_X       40    // dino left edge
`define DINO_W       20
`define CACTUS_W     20
`define CACTUS_H     30

// ##############################
// motion and scoring
// ##############################
`define SPEED        10    // cactus pixels per tick
`define JUMP_V       20    // launch velocity
`define GRAVITY      2     // velocity lost per tick
`define WIN_SCORE    5     // cleared cacti to win

`endif

// File: src/cactus_mover.sv
`timescale 1ns/10ps
`default_nettype none

`include "dino_game_params.svh"

module cactus_mover (
    input  logic                       clk,
    input  logic                       rst,
    input  dino_game_pkg::game_state_t state,
    input  logic                       tick,
    output logic [`X_W-1:0]            cactus_x,
    output logic                       cleared
);

    localparam logic [`X_W-1:0] start_x = `X_W'(`START_X);
    localparam logic [`X_W-1:0] speed   = `X_W'(`SPEED);

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            cactus_x <= start_x;
            cleared  <= 1'b0;
        end else begin
            cleared <= 1'b0;           // pulse by default low
            if (state == dino_game_pkg::idle) begin
                cactus_x <= start_x;
            end else if (state == dino_game_pkg::run && tick) begin
                if (cactus_x < speed) begin
                    cactus_x <= start_x;   // off screen so back to spawn
                    cleared  <= 1'b1;
                end else begin
                    cactus_x <= cactus_x - speed;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/collision_detector.sv
`timescale 1ns/10ps
`default_nettype none

`include "dino_game_params.svh"

module collision_detector (
    input  logic                       clk,
    input  logic                       rst,
    input  dino_game_pkg::game_state_t state,
    input  logic [`Y_W-1:0]            dino_y,
    input  logic [`X_W-1:0]            cactus_x,
    output logic                       hit
);

    localparam int ext_w = `X_W + 1;   // room for right edge

    logic [`X_W:0] cactus_l;
    logic [`X_W:0] cactus_r;
    logic          overlap_x;
    logic          low_enough;

    assign cactus_l   = {1'b0, cactus_x};
    assign cactus_r   = cactus_l + ext_w'(`CACTUS_W);
    assign overlap_x  = (cactus_l < ext_w'(`DINO_X + `DINO_W)) && (cactus_r > ext_w'(`DINO_X));
    assign low_enough = dino_y < `Y_W'(`CACTUS_H);   // dino not above the cactus top

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            hit <= 1'b0;
        end else begin
            hit <= overlap_x && low_enough && (state == dino_game_pkg::run);
        end
    end

endmodule

`default_nettype wire

// File: src/dino_game.sv
`timescale 1ns/10ps
`default_nettype none

`include "dino_game_params.svh"

module dino_game (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       up,
    output dino_game_pkg::game_state_t state,
    output logic [`Y_W-1:0]            dino_y,
    output logic [`X_W-1:0]            cactus_x,
    output logic                       collides,
    output logic [6:0]                 ones_seg,
    output logic [6:0]                 tens_seg
);

    logic tick;                        // frame tick
    logic press;                       // button edge
    logic cleared;                     // cactus wrapped
    logic won;

    // ##############################
    // timing and control
    // ##############################
    frame_timer frame_timer0 (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    game_fsm game_fsm0 (
        .clk   (clk),
        .rst   (rst),
        .up    (up),
        .hit   (collides),
        .won   (won),
        .state (state),
        .press (press)
    );

    // ##############################
    // objects and scoring
    // ##############################
    dino_jump dino_jump0 (
        .clk    (clk),
        .rst    (rst),
        .state  (state),
        .press  (press),
        .tick   (tick),
        .dino_y (dino_y)
    );

    cactus_mover cactus_mover0 (
        .clk      (clk),
        .rst      (rst),
        .state    (state),
        .tick     (tick),
        .cactus_x (cactus_x),
        .cleared  (cleared)
    );

    collision_detector collision_detector0 (
        .clk      (clk),
        .rst      (rst),
        .state    (state),
        .dino_y   (dino_y),
        .cactus_x (cactus_x),
        .hit      (collides)
    );

    score_keeper score_keeper0 (
        .clk      (clk),
        .rst      (rst),
        .state    (state),
        .cleared  (cleared),
        .won      (won),
        .ones_seg (ones_seg),
        .tens_seg (tens_seg)
    );

endmodule

`default_nettype wire

// File: src/dino_game_pkg.sv
`default_nettype none

package dino_game_pkg;

    // ##############################
    // game controller state
    // ##############################
    typedef enum logic [1:0] {
        idle = 2'd0,  // waiting for the first press
        run  = 2'd1,  // objects move on every tick
        over = 2'd2,  // dino hit a cactus
        win  = 2'd3   // enough cacti cleared
    } game_state_t;

endpackage

`default_nettype wire

// File: src/dino_jump.sv
`timescale 1ns/10ps
`default_nettype none

`include "dino_game_params.svh"

module dino_jump (
    input  logic                       clk,
    input  logic                       rst,
    input  dino_game_pkg::game_state_t state,
    input  logic                       press,
    input  logic                       tick,
    output logic [`Y_W-1:0]            dino_y
);

    // peak of the arc: sum of the non-negative velocities
    localparam int steps = `JUMP_V / `GRAVITY;
    localparam int apex  = `JUMP_V * (steps + 1) - `GRAVITY * steps * (steps + 1) / 2;

    localparam logic signed [`Y_W:0] jump_v  = `JUMP_V;
    localparam logic signed [`Y_W:0] gravity = `GRAVITY;

    logic signed [`Y_W:0]   v;         // up is positive
    logic signed [`Y_W+1:0] next_y;
    logic                   grounded;

    assign next_y   = $signed({2'b00, dino_y}) + v;
    assign grounded = (dino_y == '0) && (v == '0);

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            dino_y <= '0;
            v      <= '0;
        end else if (state == dino_game_pkg::idle) begin
            dino_y <= '0;              // back on the ground
            v      <= '0;
        end else if (state == dino_game_pkg::run) begin
            if (tick && !grounded) begin
                if (next_y <= 0) begin
                    dino_y <= '0;      // landing
                    v      <= '0;
                end else begin
                    dino_y <= next_y[`Y_W-1:0];
                    v      <= v - gravity;
                end
            end else if (press && grounded) begin
                v <= jump_v;           // launch, height moves on next tick
            end
        end
    end

    a_below_apex: assert property (@(posedge clk) disable iff (!rst) dino_y <= apex);

endmodule

`default_nettype wire

// File: src/frame_timer.sv
`timescale 1ns/10ps
`default_nettype none

`include "dino_game_params.svh"

module frame_timer (
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int cnt_w = $clog2(`FRAME_CYCLES);
    localparam logic [cnt_w-1:0] last = cnt_w'(`FRAME_CYCLES - 1);

    logic [cnt_w-1:0] cnt;

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            cnt <= '0;
        end else if (cnt == last) begin
            cnt <= '0;                 // wrap, start next frame
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign tick = (cnt == last);       // one cycle per frame

    a_tick_single: assert property (@(posedge clk) disable iff (!rst) tick |=> !tick);

endmodule

`default_nettype wire

// File: src/game_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module game_fsm (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      up,
    input  logic                      hit,
    input  logic                      won,
    output dino_game_pkg::game_state_t state,
    output logic                      press
);

    logic sync0;
    logic sync1;
    logic prev_btn;
    dino_game_pkg::game_state_t state_next;

    // ##############################
    // button sync and edge detect
    // ##############################
    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            sync0    <= 1'b0;
            sync1    <= 1'b0;
            prev_btn <= 1'b0;
        end else begin
            sync0    <= up;            // async button in
            sync1    <= sync0;
            prev_btn <= sync1;
        end
    end

    assign press = sync1 && !prev_btn; // rising edge only

    // ##############################
    // game controller
    // ##############################
    always_comb begin
        state_next = state;
        unique case (state)
            dino_game_pkg::idle: if (press) state_next = dino_game_pkg::run;
            dino_game_pkg::run: begin
                if (hit) state_next = dino_game_pkg::over;       // hit wins a tie
                else if (won) state_next = dino_game_pkg::win;
            end
            dino_game_pkg::over: if (press) state_next = dino_game_pkg::idle;
            dino_game_pkg::win:  if (press) state_next = dino_game_pkg::idle;
            default: state_next = dino_game_pkg::idle;
        endcase
    end

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) state <= dino_game_pkg::idle;
        else state <= state_next;
    end

    a_no_over_to_win: assert property (@(posedge clk) disable iff (!rst)
        state == dino_game_pkg::over |=> state != dino_game_pkg::win);

endmodule

`default_nettype wire

// File: src/score_keeper.sv
`timescale 1ns/10ps
`default_nettype none

`include "dino_game_params.svh"

module score_keeper (
    input  logic                       clk,
    input  logic                       rst,
    input  dino_game_pkg::game_state_t state,
    input  logic                       cleared,
    output logic                       won,
    output logic [6:0]                 ones_seg,
    output logic [6:0]                 tens_seg
);

    localparam logic [3:0] win_ones = 4'(`WIN_SCORE % 10);
    localparam logic [3:0] win_tens = 4'(`WIN_SCORE / 10);

    logic [3:0] ones;
    logic [3:0] tens;

    // bit 0 is segment a, active high
    function automatic logic [6:0] seven_seg(input logic [3:0] digit);
        case (digit)
            4'd0:    seven_seg = 7'h3f;
            4'd1:    seven_seg = 7'h06;
            4'd2:    seven_seg = 7'h5b;
            4'd3:    seven_seg = 7'h4f;
            4'd4:    seven_seg = 7'h66;
            4'd5:    seven_seg = 7'h6d;
            4'd6:    seven_seg = 7'h7d;
            4'd7:    seven_seg = 7'h07;
            4'd8:    seven_seg = 7'h7f;
            4'd9:    seven_seg = 7'h6f;
            default: seven_seg = 7'h00;
        endcase
    endfunction

    // ##############################
    // bcd counter
    // ##############################
    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            ones <= '0;
            tens <= '0;
        end else if (state == dino_game_pkg::idle) begin
            ones <= '0;                // new game
            tens <= '0;
        end else if (state == dino_game_pkg::run && cleared) begin
            if (ones == 4'd9) begin
                ones <= '0;
                tens <= (tens == 4'd9) ? 4'd0 : tens + 1'b1;   // carry
            end else begin
                ones <= ones + 1'b1;
            end
        end
    end

    assign won      = (ones == win_ones) && (tens == win_tens);
    assign ones_seg = seven_seg(ones);
    assign tens_seg = seven_seg(tens);

    a_ones_bcd: assert property (@(posedge clk) disable iff (!rst) ones < 4'd10);

endmodule

`default_nettype wire

// File: verif/dino_game_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "dino_game_params.svh"

module dino_game_tb;

    localparam int period        = 100;
    localparam int lap           = `START_X / `SPEED + 1;     // ticks per cactus pass
    localparam int jump_lo       = 14;  // earliest launch tick in a lap, prior jump has landed
    localparam int jump_span     = 10;  // launch up to tick 23 still clears x = 50..30
    localparam int expect_frames = lap * (`WIN_SCORE + 1) + 20;
    localparam longint watchdog_ns = 64'd2 * expect_frames * `FRAME_CYCLES * period;

    logic clk;
    logic rst;
    logic up;
    dino_game_pkg::game_state_t state;
    logic [`Y_W-1:0] dino_y;
    logic [`X_W-1:0] cactus_x;
    logic collides;
    logic [6:0] ones_seg;
    logic [6:0] tens_seg;

    int cyc    = 0;                    // clocks since reset release
    int errors = 0;
    int checks = 0;
    int seed   = 32'h572a_7983;
    int target;

    // ##############################
    // reference model state
    // ##############################
    dino_game_pkg::game_state_t exp_state = dino_game_pkg::idle;
    bit in_run    = 0;
    int run_ticks = 0;
    int jump_at   = -1;                // run tick of the last launch
    int score     = 0;
    int exp_x     = `START_X;
    int exp_y     = 0;
    bit exp_hit   = 0;

    dino_game dut0 (
        .clk      (clk),
        .rst      (rst),
        .up       (up),
        .state    (state),
        .dino_y   (dino_y),
        .cactus_x (cactus_x),
        .collides (collides),
        .ones_seg (ones_seg),
        .tens_seg (tens_seg)
    );

    function automatic int dino_height(input int k);
        int y;
        int v;
        y = 0;
        v = `JUMP_V;
        for (int i = 0; i < k; i++) begin
            if (y == 0 && v == 0) break;   // already landed
            if (y + v <= 0) begin
                y = 0;
                v = 0;
            end else begin
                y = y + v;
                v = v - `GRAVITY;
            end
        end
        return y;
    endfunction

    function automatic int cactus_pos(input int n);
        int x;
        x = `START_X;
        repeat (n) begin
            if (x < `SPEED) x = `START_X;
            else x = x - `SPEED;
        end
        return x;
    endfunction

    // segments gfedcba, active high
    function automatic logic [6:0] seg_pattern(input int d);
        case (d)
            0: return 7'b0111111;
            1: return 7'b0000110;
            2: return 7'b1011011;
            3: return 7'b1001111;
            4: return 7'b1100110;
            5: return 7'b1101101;
            6: return 7'b1111101;
            7: return 7'b0000111;
            8: return 7'b1111111;
            9: return 7'b1101111;
            default: return 7'b0000000;
        endcase
    endfunction

    function automatic bit boxes_overlap(input int x, input int y);
        return (x < `DINO_X + `DINO_W) && (x + `CACTUS_W > `DINO_X) && (y < `CACTUS_H);
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("** Error: %s expected %h, got %h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic wait_mid_frame();
        @(negedge clk);
        while (cyc % `FRAME_CYCLES != 4) @(negedge clk);
    endtask

    task automatic push_button();
        up = 1;                        // press lands 3 clocks later, well before the next tick
        repeat (4) @(negedge clk);
        up = 0;
    endtask

    task automatic start_run();
        in_run    = 1;
        run_ticks = 0;
        jump_at   = -1;
        exp_state = dino_game_pkg::run;
    endtask

    task automatic back_to_idle();
        in_run    = 0;
        score     = 0;
        exp_x     = `START_X;
        exp_y     = 0;
        exp_state = dino_game_pkg::idle;
    endtask

    initial begin
        clk = 0;
        forever #(period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst) cyc <= cyc + 1;
    end

    // ##############################
    // checker, two clocks after each tick
    // ##############################
    always @(negedge clk) begin
        if (rst && cyc % `FRAME_CYCLES == 2) begin
            exp_hit = 0;
            if (in_run) begin
                if (cactus_pos(run_ticks) < `SPEED) score++;   // this tick wraps
                run_ticks++;
                exp_x = cactus_pos(run_ticks);
                exp_y = (jump_at < 0) ? 0 : dino_height(run_ticks - jump_at);
                if (boxes_overlap(exp_x, exp_y)) begin
                    exp_hit   = 1;
                    in_run    = 0;
                    exp_state = dino_game_pkg::over;
                end else if (score == `WIN_SCORE) begin
                    in_run    = 0;
                    exp_state = dino_game_pkg::win;
                end
            end
            check_field("state", exp_state, state);
            check_field("dino_y", exp_y, dino_y);
            check_field("cactus_x", exp_x, cactus_x);
            check_field("collides", exp_hit, collides);
            check_field("ones_seg", seg_pattern(score % 10), ones_seg);
            check_field("tens_seg", seg_pattern(score / 10), tens_seg);
        end
    end

    initial begin
        #(watchdog_ns);
        $display("Timeout: the game sequence did not reach its end in time");
        $display("Finished with errors");
        $finish;
    end

    // ##############################
    // stimulus
    // ##############################
    initial begin
        rst = 0;
        up  = 0;
        repeat (16) @(negedge clk);
        rst = 1;
        repeat (4) wait_mid_frame();   // idle, nothing moves

        wait_mid_frame();
        push_button();
        start_run();
        for (int c = 0; c < `WIN_SCORE; c++) begin
            target = c * lap + jump_lo + {$random(seed)} % jump_span;
            do wait_mid_frame(); while (run_ticks < target);
            push_button();
            jump_at = run_ticks;
            if (c == 0) begin
                repeat (3) wait_mid_frame();
                push_button();         // airborne, must be ignored
            end
        end
        do wait_mid_frame(); while (exp_state != dino_game_pkg::win);
        repeat (3) wait_mid_frame();
        wait_mid_frame();
        push_button();
        back_to_idle();
        repeat (3) wait_mid_frame();

        // second run without a jump ends on the first cactus
        wait_mid_frame();
        push_button();
        start_run();
        do wait_mid_frame(); while (exp_state != dino_game_pkg::over);
        repeat (3) wait_mid_frame();
        wait_mid_frame();
        push_button();
        back_to_idle();
        repeat (2) wait_mid_frame();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
